/* filelist.f */
+incdir+.
soc_pkg.sv
bus_arbiter.sv
scratch_ram.sv
io_regs.sv
bus_decoder.sv
soc_top.sv
tb_soc.sv

/* Bender.yml */
package:
  name: soc_bus

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - bus_arbiter.sv
      - scratch_ram.sv
      - io_regs.sv
      - bus_decoder.sv
      - soc_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_soc.sv

/* tb_soc.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module tb_soc import soc_pkg::*; ();

  localparam int IDX_W = $clog2(`SOC_RAM_WORDS);
  localparam int CYCLE_LIMIT = 20000;

  typedef struct packed {
    logic err;
    data_t rdata;
    logic [31:0] due;
  } exp_t;

  logic clk;
  logic rst;
  logic cpu_valid;
  cpu_req_t cpu_req;
  logic cpu_ready;
  bus_rsp_t cpu_rsp;
  logic vga_valid;
  addr_t vga_addr;
  logic vga_ready;
  bus_rsp_t vga_rsp;
  logic [17:0] sw;
  logic [17:0] ledr;
  logic [6:0] hex0;
  logic [6:0] hex1;
  logic [6:0] hex2;
  logic [6:0] hex3;

  integer seed;
  int cycle;
  int xfer_cycle;
  string test_name;
  int test_errs;
  int tests_ok;
  int tests_bad;
  data_t ram_model [`SOC_RAM_WORDS];
  logic [15:0] disp_model;
  logic [17:0] led_model;
  master_e last_model;
  exp_t cpu_q [$];
  exp_t vga_q [$];
  addr_t wr_addr [200];

  soc_top dut (
    .clk(clk), .rst(rst),
    .cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready), .cpu_rsp(cpu_rsp),
    .vga_valid(vga_valid), .vga_addr(vga_addr), .vga_ready(vga_ready), .vga_rsp(vga_rsp),
    .sw(sw), .ledr(ledr), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic data_t rand_word();
    rand_word = $random(seed);
  endfunction

  // active high gfedcba, the board digits are the inverse
  function automatic logic [6:0] seg_on(input logic [3:0] d);
    logic [6:0] t [16];
    t = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
          7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
    seg_on = t[d];
  endfunction

  function automatic addr_t io_addr(input logic [3:0] off);
    io_addr = (rand_word() & 32'h0fff_fff0) | {`SOC_REGION_IO, 28'h0} | 32'(off);
  endfunction

  function automatic addr_t unmapped_addr();
    addr_t a;
    a = rand_word();
    if (a[31:28] == `SOC_REGION_RAM || a[31:28] == `SOC_REGION_IO) a[31:28] = a[31:28] + 4'h1;
    unmapped_addr = a;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s: %s", test_name, msg);
    test_errs++;
  endtask

  task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
    test_errs++;
  endtask

  // model side of a transfer, expected response pushed for the issuing master
  task automatic record(input master_e m, input logic write, input addr_t addr,
                        input data_t wdata, input be_t be);
    exp_t e;
    int idx;
    logic [3:0] off;
    e = '0;
    e.due = cycle + 2;
    idx = (addr >> 2) % `SOC_RAM_WORDS;
    off = addr[3:0];
    if (addr[31:28] == `SOC_REGION_RAM) begin
      for (int b = 0; b < 4; b++) begin
        if (write && be[b]) ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
      end
      if (!write) e.rdata = ram_model[idx];
    end else if (addr[31:28] == `SOC_REGION_IO) begin
      if (write && off == `SOC_IO_DISP) begin
        if (be[0]) disp_model[7:0] = wdata[7:0];
        if (be[1]) disp_model[15:8] = wdata[15:8];
      end else if (write && off == `SOC_IO_LED) begin
        if (be[0]) led_model[7:0] = wdata[7:0];
        if (be[1]) led_model[15:8] = wdata[15:8];
        if (be[2]) led_model[17:16] = wdata[17:16];
      end else if (!write) begin
        if (off == `SOC_IO_DISP) e.rdata = disp_model;
        else if (off == `SOC_IO_LED) e.rdata = led_model;
        else if (off == `SOC_IO_SW) e.rdata = sw;
      end
    end else begin
      e.err = 1'b1;
    end
    last_model = m;
    if (m == MASTER_CPU) cpu_q.push_back(e);
    else vga_q.push_back(e);
  endtask

  task automatic check_port(input master_e m, input bus_rsp_t rsp);
    exp_t e;
    logic due_now;
    due_now = 1'b0;
    if (m == MASTER_CPU && cpu_q.size() > 0) due_now = (cpu_q[0].due == cycle);
    if (m == MASTER_VGA && vga_q.size() > 0) due_now = (vga_q[0].due == cycle);
    if (due_now) begin
      if (m == MASTER_CPU) e = cpu_q.pop_front();
      else e = vga_q.pop_front();
      assert (rsp === {1'b1, e.err, e.rdata})
        else report_value(m == MASTER_CPU ? "cpu rsp" : "vga rsp", {1'b1, e.err, e.rdata}, rsp);
    end else begin
      assert (rsp.valid === 1'b0) else report_fail("a response arrived with none due");
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycle);
      $display("test failed");
      $finish;
    end
  end

  // bus monitor, responses first since they belong to older transfers
  always @(posedge clk) begin
    if (!rst) begin
      check_port(MASTER_CPU, cpu_rsp);
      check_port(MASTER_VGA, vga_rsp);
      if (cpu_valid && vga_valid) begin
        assert (cpu_ready == (last_model == MASTER_VGA) && vga_ready == !cpu_ready)
          else report_fail("a tie was not granted to the master that waited");
      end else begin
        assert (cpu_ready == cpu_valid && vga_ready == vga_valid)
          else report_fail("a lone request was not ready");
      end
      if (cpu_valid && cpu_ready) record(MASTER_CPU, cpu_req.write, cpu_req.addr,
                                         cpu_req.wdata, cpu_req.be);
      else if (vga_valid && vga_ready) record(MASTER_VGA, 1'b0, vga_addr, '0, 4'hf);
    end
  end

  task automatic cpu_issue(input logic write, input addr_t addr, input data_t wdata,
                           input be_t be);
    cpu_valid = 1'b1;
    cpu_req = '{write: write, addr: addr, wdata: wdata, be: be};
    @(posedge clk);
    while (!cpu_ready) @(posedge clk);
    xfer_cycle = cycle;
    #1;
    cpu_valid = 1'b0;
  endtask

  task automatic vga_issue(input addr_t addr);
    vga_valid = 1'b1;
    vga_addr = addr;
    @(posedge clk);
    while (!vga_ready) @(posedge clk);
    xfer_cycle = cycle;
    #1;
    vga_valid = 1'b0;
  endtask

  task automatic drain();
    while (cpu_q.size() > 0 || vga_q.size() > 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic check_outputs();
    logic [27:0] exp_hex;
    exp_hex = {~seg_on(disp_model[15:12]), ~seg_on(disp_model[11:8]),
               ~seg_on(disp_model[7:4]), ~seg_on(disp_model[3:0])};
    assert (ledr === led_model) else report_value("ledr", led_model, ledr);
    assert ({hex3, hex2, hex1, hex0} === exp_hex)
      else report_value("hex3..hex0", exp_hex, {hex3, hex2, hex1, hex0});
  endtask

  task automatic end_test();
    $display("%s done, %0d errors", test_name, test_errs);
    if (test_errs == 0) tests_ok++;
    else tests_bad++;
    test_errs = 0;
  endtask

  initial begin
    int i;
    int stop;
    int prev;
    addr_t a;
    seed = 36;
    cycle = 0;
    rst = 1'b1;
    cpu_valid = 1'b0;
    cpu_req = '0;
    vga_valid = 1'b0;
    vga_addr = '0;
    sw = '0;
    disp_model = '0;
    led_model = '0;
    last_model = MASTER_VGA;
    test_errs = 0;
    tests_ok = 0;
    tests_bad = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "reset_state";
    assert (cpu_rsp.valid === 1'b0 && vga_rsp.valid === 1'b0)
      else report_fail("a response was valid right after reset");
    check_outputs();
    end_test();

    // fill first so partial writes never merge into unknown bytes
    test_name = "ram_rw";
    for (i = 0; i < `SOC_RAM_WORDS; i++) begin
      a = i * 4;
      cpu_issue(1'b1, a, (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]}, 4'hf);
    end
    for (i = 0; i < 200; i++) begin
      wr_addr[i] = rand_word() & 32'h0fff_fffc;
      cpu_issue(1'b1, wr_addr[i], rand_word(), be_t'(rand_word()));
    end
    for (i = 0; i < 200; i++) begin
      // same word through an alias above the depth
      a = wr_addr[i] ^ ((rand_word() << (IDX_W + 2)) & 32'h0fff_ffff);
      cpu_issue(1'b0, a, '0, 4'hf);
    end
    drain();
    end_test();

    test_name = "io_regs";
    for (i = 0; i < 40; i++) begin
      sw = 18'(rand_word());
      a = io_addr(4'(rand_word() % 4) * 4'h4);
      cpu_issue(1'b1, a, rand_word(), be_t'(rand_word()));
      cpu_issue(1'b0, io_addr(`SOC_IO_DISP), '0, 4'hf);
      cpu_issue(1'b0, io_addr(`SOC_IO_LED), '0, 4'hf);
      cpu_issue(1'b0, io_addr(`SOC_IO_SW), '0, 4'hf);
      cpu_issue(1'b0, io_addr(4'hd), '0, 4'hf);
      drain();
      check_outputs();
    end
    end_test();

    test_name = "unmapped";
    for (i = 0; i < 30; i++) begin
      cpu_issue(rand_word() % 2 == 1, unmapped_addr(), rand_word(), be_t'(rand_word()));
      vga_issue(unmapped_addr());
    end
    for (i = 0; i < `SOC_RAM_WORDS; i++) cpu_issue(1'b0, i * 4, '0, 4'hf);
    cpu_issue(1'b0, io_addr(`SOC_IO_DISP), '0, 4'hf);
    cpu_issue(1'b0, io_addr(`SOC_IO_LED), '0, 4'hf);
    drain();
    check_outputs();
    end_test();

    // small window so both masters hit the same words
    test_name = "arbitration";
    stop = cycle + 150;
    fork
      while (cycle < stop) cpu_issue(rand_word() % 2 == 1, rand_word() & 32'h1c,
                                     rand_word(), be_t'(rand_word()));
      for (int n = 0; cycle < stop; n++) vga_issue((n * 4) & 32'h1c);
    join
    drain();
    end_test();

    test_name = "back_to_back";
    prev = 0;
    for (i = 0; i < 48; i++) begin
      if (i < 24) cpu_issue(rand_word() % 2 == 1, rand_word() & 32'h3fc, rand_word(), 4'hf);
      else vga_issue(i % 3 == 0 ? io_addr(`SOC_IO_LED) : rand_word() & 32'h3fc);
      assert (i == 0 || i == 24 || xfer_cycle == prev + 1)
        else report_fail("requests did not transfer on consecutive cycles");
      prev = xfer_cycle;
    end
    drain();
    end_test();

    $display("summary: %0d tests clean, %0d tests with errors", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; (
  input logic clk,
  input logic rst,
  input logic cpu_valid,
  input cpu_req_t cpu_req,
  output logic cpu_ready,
  output bus_rsp_t cpu_rsp,
  input logic vga_valid,
  input addr_t vga_addr,
  output logic vga_ready,
  output bus_rsp_t vga_rsp,
  input logic [17:0] sw,
  output logic [17:0] ledr,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3
);

  bus_cmd_t cmd;
  logic ram_sel;
  logic io_sel;
  data_t ram_rdata;
  data_t io_rdata;

  bus_arbiter arb0 (
    .clk(clk),
    .rst(rst),
    .cpu_valid(cpu_valid),
    .cpu_req(cpu_req),
    .cpu_ready(cpu_ready),
    .vga_valid(vga_valid),
    .vga_addr(vga_addr),
    .vga_ready(vga_ready),
    .cmd(cmd)
  );

  // both slaves see the same command, the selects pick one
  scratch_ram ram0 (
    .clk(clk),
    .sel(ram_sel),
    .cmd(cmd),
    .rdata(ram_rdata)
  );

  io_regs io0 (
    .clk(clk),
    .rst(rst),
    .sel(io_sel),
    .cmd(cmd),
    .rdata(io_rdata),
    .sw(sw),
    .ledr(ledr),
    .hex0(hex0),
    .hex1(hex1),
    .hex2(hex2),
    .hex3(hex3)
  );

  bus_decoder dec0 (
    .clk(clk),
    .rst(rst),
    .cmd(cmd),
    .ram_sel(ram_sel),
    .io_sel(io_sel),
    .ram_rdata(ram_rdata),
    .io_rdata(io_rdata),
    .cpu_rsp(cpu_rsp),
    .vga_rsp(vga_rsp)
  );

endmodule

`default_nettype wire

/* bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module bus_decoder import soc_pkg::*; (
  input logic clk,
  input logic rst,
  input bus_cmd_t cmd,
  output logic ram_sel,
  output logic io_sel,
  input data_t ram_rdata,
  input data_t io_rdata,
  output bus_rsp_t cpu_rsp,
  output bus_rsp_t vga_rsp
);

  region_t region;
  region_t rsp_region;
  master_e rsp_master;
  logic rsp_valid;
  logic hit_ram;
  logic hit_io;
  data_t rsp_data;

  assign region = cmd.addr[31:28];
  assign ram_sel = cmd.valid && (region == `SOC_REGION_RAM);
  assign io_sel = cmd.valid && (region == `SOC_REGION_IO);

  // tag follows the command into the slave read stage
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      rsp_master <= MASTER_CPU;
      rsp_region <= '0;
    end else begin
      rsp_valid <= cmd.valid;
      rsp_master <= cmd.master;
      rsp_region <= region;
    end
  end

  always_comb begin
    hit_ram = (rsp_region == `SOC_REGION_RAM);
    hit_io = (rsp_region == `SOC_REGION_IO);
    if (hit_ram) begin
      rsp_data = ram_rdata;
    end else if (hit_io) begin
      rsp_data = io_rdata;
    end else begin
      // unmapped region
      rsp_data = '0;
    end
  end

  always_comb begin
    cpu_rsp.valid = rsp_valid && (rsp_master == MASTER_CPU);
    cpu_rsp.err = !(hit_ram || hit_io);
    cpu_rsp.rdata = rsp_data;
    vga_rsp.valid = rsp_valid && (rsp_master == MASTER_VGA);
    vga_rsp.err = !(hit_ram || hit_io);
    vga_rsp.rdata = rsp_data;
  end

endmodule

`default_nettype wire

/* io_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module io_regs import soc_pkg::*; (
  input logic clk,
  input logic rst,
  input logic sel,
  input bus_cmd_t cmd,
  output data_t rdata,
  input logic [17:0] sw,
  output logic [17:0] ledr,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3
);

  logic [15:0] disp;
  logic [3:0] offset;

  // active low, bit 0 is segment a
  function automatic logic [6:0] seg7(input logic [3:0] digit);
    case (digit)
      4'h0: seg7 = 7'b1000000;
      4'h1: seg7 = 7'b1111001;
      4'h2: seg7 = 7'b0100100;
      4'h3: seg7 = 7'b0110000;
      4'h4: seg7 = 7'b0011001;
      4'h5: seg7 = 7'b0010010;
      4'h6: seg7 = 7'b0000010;
      4'h7: seg7 = 7'b1111000;
      4'h8: seg7 = 7'b0000000;
      4'h9: seg7 = 7'b0010000;
      4'ha: seg7 = 7'b0001000;
      4'hb: seg7 = 7'b0000011;
      4'hc: seg7 = 7'b1000110;
      4'hd: seg7 = 7'b0100001;
      4'he: seg7 = 7'b0000110;
      default: seg7 = 7'b0001110;
    endcase
  endfunction

  assign offset = cmd.addr[3:0];

  // writes to the switch offset or unused offsets fall through
  always_ff @(posedge clk) begin
    if (rst) begin
      disp <= '0;
      ledr <= '0;
    end else if (sel && cmd.write) begin
      if (offset == `SOC_IO_DISP) begin
        if (cmd.be[0]) disp[7:0] <= cmd.wdata[7:0];
        if (cmd.be[1]) disp[15:8] <= cmd.wdata[15:8];
      end else if (offset == `SOC_IO_LED) begin
        if (cmd.be[0]) ledr[7:0] <= cmd.wdata[7:0];
        if (cmd.be[1]) ledr[15:8] <= cmd.wdata[15:8];
        if (cmd.be[2]) ledr[17:16] <= cmd.wdata[17:16];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel && !cmd.write) begin
      case (offset)
        `SOC_IO_DISP: rdata <= data_t'(disp);
        `SOC_IO_LED: rdata <= data_t'(ledr);
        `SOC_IO_SW: rdata <= data_t'(sw);
        default: rdata <= '0;
      endcase
    end else begin
      rdata <= '0;
    end
  end

  // hex0 shows the low nibble
  assign hex0 = seg7(disp[3:0]);
  assign hex1 = seg7(disp[7:4]);
  assign hex2 = seg7(disp[11:8]);
  assign hex3 = seg7(disp[15:12]);

endmodule

`default_nettype wire

/* scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module scratch_ram import soc_pkg::*; (
  input logic clk,
  input logic sel,
  input bus_cmd_t cmd,
  output data_t rdata
);

  localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

  data_t mem [`SOC_RAM_WORDS];
  logic [IDX_W-1:0] idx;

  // word index, upper address bits dropped so it wraps
  assign idx = cmd.addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (sel && cmd.write) begin
      for (int b = 0; b < 4; b++) begin
        if (cmd.be[b]) begin
          mem[idx][8*b +: 8] <= cmd.wdata[8*b +: 8];
        end
      end
    end
  end

  // zero unless a read is selected, keeps write responses clean
  always_ff @(posedge clk) begin
    if (sel && !cmd.write) begin
      rdata <= mem[idx];
    end else begin
      rdata <= '0;
    end
  end

endmodule

`default_nettype wire

/* bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import soc_pkg::*; (
  input logic clk,
  input logic rst,
  input logic cpu_valid,
  input cpu_req_t cpu_req,
  output logic cpu_ready,
  input logic vga_valid,
  input addr_t vga_addr,
  output logic vga_ready,
  output bus_cmd_t cmd
);

  master_e last_grant;

  // round robin, loser of the last tie goes first
  // at most one ready is high, so ready also marks the transfer
  always_comb begin
    cpu_ready = cpu_valid && (!vga_valid || last_grant == MASTER_VGA);
    vga_ready = vga_valid && (!cpu_valid || last_grant == MASTER_CPU);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_grant <= MASTER_VGA;
    end else if (cpu_ready) begin
      last_grant <= MASTER_CPU;
    end else if (vga_ready) begin
      last_grant <= MASTER_VGA;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= cpu_ready || vga_ready;
    end
  end

  // command payload, only loaded on a transfer
  always_ff @(posedge clk) begin
    if (cpu_ready) begin
      cmd.master <= MASTER_CPU;
      cmd.write <= cpu_req.write;
      cmd.addr <= cpu_req.addr;
      cmd.wdata <= cpu_req.wdata;
      cmd.be <= cpu_req.be;
    end else if (vga_ready) begin
      // display fetch is always a full word read
      cmd.master <= MASTER_VGA;
      cmd.write <= 1'b0;
      cmd.addr <= vga_addr;
      cmd.wdata <= '0;
      cmd.be <= '1;
    end
  end

endmodule

`default_nettype wire

/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] be_t;
  typedef logic [3:0] region_t;

  // source tag on a command, also the arbiter's last grant
  typedef enum logic {
    MASTER_CPU,
    MASTER_VGA
  } master_e;

  typedef struct packed {
    logic write;
    addr_t addr;
    data_t wdata;
    be_t be;
  } cpu_req_t;

  typedef struct packed {
    logic valid;
    master_e master;
    logic write;
    addr_t addr;
    data_t wdata;
    be_t be;
  } bus_cmd_t;

  typedef struct packed {
    logic valid;
    logic err;
    data_t rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

/* soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// scratch RAM depth in 32-bit words, addresses wrap above it
`define SOC_RAM_WORDS 256

// region codes from addr[31:28]
`define SOC_REGION_RAM 4'h0
`define SOC_REGION_IO 4'h4

// io register offsets from addr[3:0]
`define SOC_IO_DISP 4'h0
`define SOC_IO_LED 4'h4
`define SOC_IO_SW 4'h8

`endif
